// ==== logic/execUnit_settings.svh ====
`ifndef EXEC_UNIT_SETTINGS_SVH
`define EXEC_UNIT_SETTINGS_SVH

// width of a register value and of every ALU result.
`define EXEC_XLEN 32

// width of a program counter and of a jump target.
`define EXEC_ALEN 32

// width of a reorder-buffer entry tag.
// sixteen entries in flight.
`define EXEC_TAG_W 4

// mask width for the shift amount on RV32.
`define EXEC_SHAMT_W 5

`endif

// ==== logic/execPkg.sv ====
`include "execUnit_settings.svh"

package execPkg;

    // operation codes handed over by the reservation stations.
    typedef enum logic [4:0] {
        opInvalid = 5'd0,
        opLui     = 5'd1,
        opAuipc   = 5'd2,
        opJal     = 5'd3,
        opJalr    = 5'd4,
        opBeq     = 5'd5,
        opBne     = 5'd6,
        opBlt     = 5'd7,
        opBge     = 5'd8,
        opBltu    = 5'd9,
        opBgeu    = 5'd10,
        opAddi    = 5'd11,
        opSlti    = 5'd12,
        opSltiu   = 5'd13,
        opXori    = 5'd14,
        opOri     = 5'd15,
        opAndi    = 5'd16,
        opSlli    = 5'd17,
        opSrli    = 5'd18,
        opSrai    = 5'd19,
        opAdd     = 5'd20,
        opSub     = 5'd21,
        opSll     = 5'd22,
        opSlt     = 5'd23,
        opSltu    = 5'd24,
        opXor     = 5'd25,
        opSrl     = 5'd26,
        opSra     = 5'd27,
        opOr      = 5'd28,
        opAnd     = 5'd29
    } opKind;

    // one operand-ready instruction with imm already sign-extended.
    typedef struct packed {
        logic [`EXEC_ALEN-1:0]  pc;
        opKind                  op;
        logic [`EXEC_XLEN-1:0]  imm;
        logic [`EXEC_TAG_W-1:0] tag;
        logic [`EXEC_XLEN-1:0]  rs1Val;
        logic [`EXEC_XLEN-1:0]  rs2Val;
    } issueSlot;

    // common data bus word seen by rs, load-store buffer and rob.
    typedef struct packed {
        logic                   valid;
        logic [`EXEC_TAG_W-1:0] tag;
        logic [`EXEC_XLEN-1:0]  data;
    } cdbWord;

    // jump outcome for the reorder buffer only.
    typedef struct packed {
        logic                  jump;
        logic [`EXEC_ALEN-1:0] target;
    } jumpVerdict;

endpackage

// ==== logic/aluPath.sv ====
`timescale 1ns/10ps
`include "execUnit_settings.svh"

module aluPath (
    input  execPkg::issueSlot     slot,
    output logic [`EXEC_XLEN-1:0] value
);
    import execPkg::*;

    logic                     regForm;
    logic [`EXEC_XLEN-1:0]    opA;
    logic [`EXEC_XLEN-1:0]    opB;
    logic [`EXEC_SHAMT_W-1:0] shamt;
    logic                     ltSigned;
    logic                     ltUnsigned;
    logic [`EXEC_XLEN-1:0]    pcRel;
    logic [`EXEC_XLEN-1:0]    linkAddr;

    // register forms read rs2, the immediate forms read imm.
    always_comb begin
        regForm = slot.op inside {opAdd, opSub, opSll, opSlt, opSltu,
                                  opXor, opSrl, opSra, opOr, opAnd};
    end

    assign opA = slot.rs1Val;
    assign opB = regForm ? slot.rs2Val : slot.imm;

    // RV32 only looks at the low five bits of the amount.
    assign shamt = opB[`EXEC_SHAMT_W-1:0];

    assign ltSigned   = $signed(opA) < $signed(opB);
    assign ltUnsigned = opA < opB;

    assign pcRel    = slot.pc + slot.imm;
    assign linkAddr = slot.pc + `EXEC_ALEN'(4);

    always_comb begin
        case (slot.op)
            opLui: begin
                value = slot.imm;
            end
            opAuipc: begin
                value = pcRel;
            end
            // return address for the link register.
            opJal, opJalr: begin
                value = linkAddr;
            end
            opAdd, opAddi: begin
                value = opA + opB;
            end
            opSub: begin
                value = opA - opB;
            end
            opSll, opSlli: begin
                value = opA << shamt;
            end
            opSlt, opSlti: begin
                value = `EXEC_XLEN'(ltSigned);
            end
            opSltu, opSltiu: begin
                value = `EXEC_XLEN'(ltUnsigned);
            end
            opXor, opXori: begin
                value = opA ^ opB;
            end
            opSrl, opSrli: begin
                value = opA >> shamt;
            end
            opSra, opSrai: begin
                value = $signed(opA) >>> shamt;
            end
            opOr, opOri: begin
                value = opA | opB;
            end
            opAnd, opAndi: begin
                value = opA & opB;
            end
            // branches write no register.
            default: begin
                value = '0;
            end
        endcase
    end

endmodule

// ==== logic/branchPath.sv ====
`timescale 1ns/10ps
`include "execUnit_settings.svh"

module branchPath (
    input  execPkg::issueSlot     slot,
    output logic                  jump,
    output logic [`EXEC_ALEN-1:0] target
);
    import execPkg::*;

    logic                  isEqual;
    logic                  ltSigned;
    logic                  ltUnsigned;
    logic [`EXEC_ALEN-1:0] pcTarget;
    logic [`EXEC_ALEN-1:0] regTarget;

    // three compares cover all six branch kinds.
    assign isEqual    = slot.rs1Val == slot.rs2Val;
    assign ltSigned   = $signed(slot.rs1Val) < $signed(slot.rs2Val);
    assign ltUnsigned = slot.rs1Val < slot.rs2Val;

    always_comb begin
        case (slot.op)
            opBeq:         jump = isEqual;
            opBne:         jump = !isEqual;
            opBlt:         jump = ltSigned;
            opBge:         jump = !ltSigned;
            opBltu:        jump = ltUnsigned;
            opBgeu:        jump = !ltUnsigned;
            opJal, opJalr: jump = 1'b1;
            default:       jump = 1'b0;
        endcase
    end

    assign pcTarget  = slot.pc + slot.imm;
    assign regTarget = slot.rs1Val + slot.imm;

    // jalr drops bit 0 of the sum, every other kind is pc relative.
    // the rob compares this against the front end's guess, even for jal.
    always_comb begin
        if (slot.op == opJalr) begin
            target = {regTarget[`EXEC_ALEN-1:1], 1'b0};
        end else begin
            target = pcTarget;
        end
    end

endmodule

// ==== logic/resultBroadcast.sv ====
`timescale 1ns/10ps
`include "execUnit_settings.svh"

module resultBroadcast (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   rdy,
    input  logic                   issueEn,
    input  logic [`EXEC_TAG_W-1:0] tag,
    input  logic [`EXEC_XLEN-1:0]  value,
    input  logic                   jump,
    input  logic [`EXEC_ALEN-1:0]  target,
    output execPkg::cdbWord        cdb,
    output execPkg::jumpVerdict    verdict
);

    logic                   validQ;
    logic                   jumpQ;
    logic [`EXEC_TAG_W-1:0] tagQ;
    logic [`EXEC_XLEN-1:0]  dataQ;
    logic [`EXEC_ALEN-1:0]  targetQ;

    // an idle accepted edge retires the previous word.
    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
            jumpQ  <= 1'b0;
        end else if (rdy) begin
            validQ <= issueEn;
            jumpQ  <= issueEn & jump;
        end
    end

    // payload only moves on a real issue.
    always_ff @(posedge clk) begin
        if (rdy && issueEn) begin
            tagQ    <= tag;
            dataQ   <= value;
            targetQ <= target;
        end
    end

    assign cdb = '{valid: validQ, tag: tagQ, data: dataQ};

    assign verdict = '{jump: jumpQ, target: targetQ};

endmodule

// ==== logic/executeUnit.sv ====
`timescale 1ns/10ps
`include "execUnit_settings.svh"

module executeUnit (
    input  logic                clk,
    input  logic                rst,
    input  logic                rdy,
    input  logic                issueEn,
    input  execPkg::issueSlot   slot,
    output execPkg::cdbWord     cdb,
    output execPkg::jumpVerdict verdict
);

    logic [`EXEC_XLEN-1:0] value;
    logic                  jump;
    logic [`EXEC_ALEN-1:0] target;

    // both paths see the same slot in the same cycle.
    aluPath aluPathInst (
        .slot  (slot),
        .value (value)
    );

    branchPath branchPathInst (
        .slot   (slot),
        .jump   (jump),
        .target (target)
    );

    resultBroadcast resultBroadcastInst (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .issueEn (issueEn),
        .tag     (slot.tag),
        .value   (value),
        .jump    (jump),
        .target  (target),
        .cdb     (cdb),
        .verdict (verdict)
    );

endmodule

// ==== verif/executeUnit_tb.sv ====
`timescale 1ns/10ps
`include "execUnit_settings.svh"

module executeUnit_tb;
    import execPkg::*;

    localparam string dataFile = "verif/execute_testdata.txt";

    // one line of the data file.
    typedef struct packed {
        logic [7:0]             testNo;
        logic [4:0]             op;
        logic [`EXEC_ALEN-1:0]  pc;
        logic [`EXEC_XLEN-1:0]  imm;
        logic [`EXEC_TAG_W-1:0] tag;
        logic [`EXEC_XLEN-1:0]  rs1Val;
        logic [`EXEC_XLEN-1:0]  rs2Val;
        logic                   writesReg;
        logic [`EXEC_XLEN-1:0]  data;
        logic                   jump;
        logic [`EXEC_ALEN-1:0]  target;
    } testVector;

    logic        clk;
    logic        rst;
    logic        rdy;
    logic        issueEn;
    issueSlot    slot;
    cdbWord      cdb;
    jumpVerdict  verdict;

    testVector   vecs[$];
    cdbWord      prevCdb;
    jumpVerdict  prevVerdict;
    logic [15:0] lfsrState = 16'd43;
    bit          loadOk = 1'b0;
    int          numLines = 0;
    int          doneLines = 0;
    int          checkCount = 0;
    int          errCount = 0;
    int          testCount = 0;

    executeUnit uut (
        .clk     (clk),
        .rst     (rst),
        .rdy     (rdy),
        .issueEn (issueEn),
        .slot    (slot),
        .cdb     (cdb),
        .verdict (verdict)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1.
    function automatic logic [15:0] lfsrNext(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    task automatic drawBit(output logic b);
        lfsrState = lfsrNext(lfsrState);
        b = lfsrState[0];
    endtask

    task automatic checkValue(input logic [63:0] got, input logic [63:0] exp,
                              input string what);
        checkCount++;
        if (got !== exp) begin
            errCount++;
            $display("** Error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic loadVectors();
        int          fd;
        int          n;
        string       line;
        logic [31:0] f [0:10];
        testVector   v;
        fd = $fopen(dataFile, "r");
        if (fd == 0) begin
            $display("cannot open the data file %s", dataFile);
            return;
        end
        while ($fgets(line, fd) != 0) begin
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h", f[0], f[1], f[2],
                        f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10]);
            if (n != 11) begin
                $display("malformed line in the data file: %s", line);
                $fclose(fd);
                return;
            end
            v.testNo    = f[0][7:0];
            v.op        = f[1][4:0];
            v.pc        = f[2];
            v.imm       = f[3];
            v.tag       = f[4][`EXEC_TAG_W-1:0];
            v.rs1Val    = f[5];
            v.rs2Val    = f[6];
            v.writesReg = f[7][0];
            v.data      = f[8];
            v.jump      = f[9][0];
            v.target    = f[10];
            vecs.push_back(v);
        end
        $fclose(fd);
        numLines = vecs.size();
        loadOk = (numLines > 0);
    endtask

    function automatic issueSlot makeSlot(input testVector v);
        issueSlot s;
        s.pc     = v.pc;
        s.op     = opKind'(v.op);
        s.imm    = v.imm;
        s.tag    = v.tag;
        s.rs1Val = v.rs1Val;
        s.rs2Val = v.rs2Val;
        return s;
    endfunction

    task automatic checkResult(input testVector v);
        string where;
        where = $sformatf("test %0d line %0d", v.testNo, doneLines + 1);
        checkValue(64'(cdb.valid), 64'(1'b1), {where, " valid"});
        checkValue(64'(cdb.tag), 64'(v.tag), {where, " tag"});
        if (v.writesReg) begin
            checkValue(64'(cdb.data), 64'(v.data), {where, " data"});
        end
        checkValue(64'(verdict.jump), 64'(v.jump), {where, " jump"});
        if (v.jump) begin
            checkValue(64'(verdict.target), 64'(v.target), {where, " target"});
        end
    endtask

    task automatic checkIdle(input string when);
        checkValue(64'(cdb.valid), 64'(1'b0), {"valid low ", when});
        checkValue(64'(verdict.jump), 64'(1'b0), {"jump low ", when});
    endtask

    // a stalled edge leaves both outputs untouched.
    task automatic checkHold();
        checkValue(64'(cdb), 64'(prevCdb), "cdb held during stall");
        checkValue(64'(verdict), 64'(prevVerdict), "verdict held during stall");
    endtask

    task automatic runVectors();
        testVector v;
        logic      gapBit;
        logic      stallBit;
        logic      held;
        logic      lastGap;
        logic      lastStall;
        int        errAtTestStart;
        int        linesInTest;
        held = 1'b0;
        lastGap = 1'b0;
        lastStall = 1'b0;
        errAtTestStart = errCount;
        linesInTest = 0;
        while (doneLines < numLines) begin
            v = vecs[doneLines];
            drawBit(gapBit);
            drawBit(stallBit);
            // gaps and stalls never come twice in a row, a held issue stays put.
            if (!held) begin
                issueEn = !(gapBit && !lastGap);
            end
            slot = makeSlot(v);
            rdy = !(stallBit && !lastStall);
            lastGap = !issueEn;
            lastStall = !rdy;
            held = issueEn && !rdy;
            @(posedge clk);
            #2;
            if (!rdy) begin
                checkHold();
            end else if (issueEn) begin
                checkResult(v);
                doneLines++;
                linesInTest++;
                if (doneLines == numLines || vecs[doneLines].testNo != v.testNo) begin
                    testCount++;
                    $display("test %0d done: %0d lines, %0d errors", v.testNo,
                             linesInTest, errCount - errAtTestStart);
                    errAtTestStart = errCount;
                    linesInTest = 0;
                end
            end else begin
                checkIdle("after a gap");
            end
            prevCdb = cdb;
            prevVerdict = verdict;
        end
        issueEn = 1'b0;
        rdy = 1'b1;
        @(posedge clk);
        #2;
        checkIdle("after the last issue");
    endtask

    initial begin : mainFlow
        rst = 1'b1;
        rdy = 1'b1;
        issueEn = 1'b0;
        slot = '0;
        loadVectors();
        if (!loadOk) begin
            $display("no usable test data was found, nothing was run");
            $display("CHECKS FAILED");
            $finish;
        end else begin
            repeat (3) @(posedge clk);
            #2;
            rst = 1'b0;
            checkIdle("after reset");
            prevCdb = cdb;
            prevVerdict = verdict;
            runVectors();
            $display("%0d tests, %0d lines, %0d checks, %0d errors", testCount, doneLines,
                     checkCount, errCount);
            if (errCount == 0) begin
                $display("ALL CHECKS PASSED");
            end else begin
                $display("CHECKS FAILED");
            end
            $finish;
        end
    end

    // at most three cycles per line, plus slack for reset.
    initial begin : watchdog
        wait (loadOk);
        repeat (numLines * 4 + 100) @(posedge clk);
        $display("simulation timed out after %0d cycles", numLines * 4 + 100);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

// ==== verif/execute_testdata.txt ====
# test op pc imm tag rs1Val rs2Val writesReg data jump target, all fields in hex
# op codes follow execPkg::opKind, target only matters when jump is 1
1 14 00001000 00000077 1 00000005 fffffffd 1 00000002 0 00000000
1 14 00001000 00000077 2 7fffffff 00000001 1 80000000 0 00000000
1 15 00001000 00000077 3 00000003 00000005 1 fffffffe 0 00000000
1 15 00001000 00000077 4 80000000 00000001 1 7fffffff 0 00000000
1 16 00001000 00000077 5 00000001 00000024 1 00000010 0 00000000
1 17 00001000 00000077 6 ffffffff 00000001 1 00000001 0 00000000
1 18 00001000 00000077 7 ffffffff 00000001 1 00000000 0 00000000
1 19 00001000 00000077 8 f0f0f0f0 0ff00ff0 1 ff00ff00 0 00000000
1 1a 00001000 00000077 9 80000000 00000021 1 40000000 0 00000000
1 1b 00001000 00000077 a 80000000 0000001f 1 ffffffff 0 00000000
1 1b 00001000 00000077 b f0000000 00000024 1 ff000000 0 00000000
1 1c 00001000 00000077 c 12340000 00005678 1 12345678 0 00000000
1 1d 00001000 00000077 d ff00ff00 0ff00ff0 1 0f000f00 0 00000000
1 18 00001000 00000077 e 00000001 ffffffff 1 00000001 0 00000000
2 0b 00001100 fffffff0 f 00000010 deadbeef 1 00000000 0 00000000
2 0c 00001104 00000003 0 fffffffb deadbeef 1 00000001 0 00000000
2 0d 00001108 ffffffff 1 00000005 00000000 1 00000001 0 00000000
2 0e 0000110c ffffffff 2 0000ffff deadbeef 1 ffff0000 0 00000000
2 0f 00001110 0000070f 3 00f000f0 deadbeef 1 00f007ff 0 00000000
2 10 00001114 00000ff0 4 12345678 deadbeef 1 00000670 0 00000000
2 11 00001118 0000001e 5 00000003 deadbeef 1 c0000000 0 00000000
2 12 0000111c 0000001c 6 f0000000 deadbeef 1 0000000f 0 00000000
2 13 00001120 00000008 7 80000000 deadbeef 1 ff800000 0 00000000
2 01 00001124 12345000 8 0000abcd deadbeef 1 12345000 0 00000000
2 02 00400000 fffff000 9 00000000 deadbeef 1 003ff000 0 00000000
2 02 00000100 00010000 a 00000000 deadbeef 1 00010100 0 00000000
3 05 00002000 00000040 b 00000007 00000007 0 00000000 1 00002040
3 05 00002004 00000040 c 00000007 00000008 0 00000000 0 00000000
3 06 00002008 ffffffe0 d 00000007 00000008 0 00000000 1 00001fe8
3 06 0000200c ffffffe0 e 00000007 00000007 0 00000000 0 00000000
3 07 00002010 00000040 f ffffffff 00000001 0 00000000 1 00002050
3 09 00002014 00000040 0 ffffffff 00000001 0 00000000 0 00000000
3 08 00002018 00000040 1 ffffffff 00000001 0 00000000 0 00000000
3 0a 0000201c ffffffe0 2 ffffffff 00000001 0 00000000 1 00001ffc
3 07 00002020 00000040 3 00000001 ffffffff 0 00000000 0 00000000
3 09 00002024 00000040 4 00000001 ffffffff 0 00000000 1 00002064
3 08 00002028 00000040 5 00000005 00000005 0 00000000 1 00002068
3 0a 0000202c 00000040 6 00000001 ffffffff 0 00000000 0 00000000
4 03 00003000 00000100 7 00000000 00000000 1 00003004 1 00003100
4 03 00003000 fffff800 8 00000000 00000000 1 00003004 1 00002800
4 04 00004000 00000004 9 00008001 00000000 1 00004004 1 00008004
4 04 00004010 fffffffb a 00010000 00000000 1 00004014 1 0000fffa

// ==== sources.f ====
+incdir+logic
logic/execPkg.sv
logic/aluPath.sv
logic/branchPath.sv
logic/resultBroadcast.sv
logic/executeUnit.sv
verif/executeUnit_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# builds the execute unit testbench with Verilator and runs it from the project root.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing -j 0 -f sources.f --top-module executeUnit_tb -o simExec

./obj_dir/simExec | tee "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation reported failures, see $LOG"
    exit 1
fi

if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation ended without a final verdict, see $LOG"
    exit 1
fi

echo "simulation finished cleanly"
